// File: rtl/match_pkg.sv
`default_nettype none

package match_pkg;

  // Stream id space of the byte port
  localparam int STREAM_ID_W = 6;
  localparam int NUM_STREAMS = 2**STREAM_ID_W;

  // Matcher state counts the literal bytes matched so far
  localparam int STATE_W = 3;

  // Longest literal that the state width can track
  localparam int MAX_PATTERN_LEN = 7;

  // Width of the match and packet counters
  localparam int COUNT_W = 16;

  // Stream id carried with every byte
  typedef logic [STREAM_ID_W-1:0] stream_id_t;

  // Number of literal bytes currently matched
  typedef logic [STATE_W-1:0] dfa_state_t;

  // Wrapping event counter
  typedef logic [COUNT_W-1:0] count_t;

endpackage

`default_nettype wire

// File: rtl/apb_map_pkg.sv
`default_nettype none

package apb_map_pkg;

  // Bus widths of the configuration port
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // Enable bits, one per stream, split over two words
  localparam logic [APB_ADDR_W-1:0] ADDR_ENABLE_LO = 8'h00;
  localparam logic [APB_ADDR_W-1:0] ADDR_ENABLE_HI = 8'h04;

  // Counters read back zero-extended, any write clears them
  localparam logic [APB_ADDR_W-1:0] ADDR_MATCH_COUNT = 8'h08;
  localparam logic [APB_ADDR_W-1:0] ADDR_PACKET_COUNT = 8'h0C;

endpackage

`default_nettype wire

// File: rtl/packet_ingress.sv
`timescale 1ns/1ns
`default_nettype none

module packet_ingress (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   in_valid,
  input  wire logic [7:0]             in_byte,
  input  wire logic                   in_sop,
  input  wire logic                   in_eop,
  input  wire match_pkg::stream_id_t  in_stream_id,
  output logic                        byte_valid,
  output logic [7:0]                  byte_data,
  output logic                        byte_sop,
  output logic                        byte_eop,
  output match_pkg::stream_id_t       byte_id,
  output logic                        byte_new
);

  // One bit per stream, set once the stream has sent a start byte
  logic [match_pkg::NUM_STREAMS-1:0] seen;

  // Start byte accepted this cycle
  logic take_sop;

  assign take_sop = in_valid & in_sop;

  // Control flags, qualified with valid so idle cycles carry no stale flag
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      byte_valid <= 1'b0;
      byte_sop   <= 1'b0;
      byte_eop   <= 1'b0;
      byte_new   <= 1'b0;
      seen       <= '0;
    end
    else
    begin
      byte_valid <= in_valid;
      byte_sop   <= take_sop;
      byte_eop   <= in_valid & in_eop;
      // First start byte of a stream since reset has no saved context
      byte_new   <= take_sop & ~seen[in_stream_id];
      if (take_sop)
      begin
        seen[in_stream_id] <= 1'b1;
      end
    end
  end

  // Payload side, only meaningful while byte_valid is high
  always_ff @(posedge clk)
  begin
    byte_data <= in_byte;
    byte_id   <= in_stream_id;
  end

endmodule

`default_nettype wire

// File: rtl/context_store.sv
`timescale 1ns/1ns
`default_nettype none

module context_store (
  input  wire logic                   clk,
  input  wire match_pkg::stream_id_t  byte_id,
  input  wire logic                   save_en,
  input  wire match_pkg::dfa_state_t  save_state,
  output match_pkg::dfa_state_t       restored_state
);

  // Matcher state of each stream as left by its last saved packet
  match_pkg::dfa_state_t state_mem [match_pkg::NUM_STREAMS];

  // Restore path
  // Read is asynchronous so a start byte sees its context in the same cycle
  assign restored_state = state_mem[byte_id];

  // Save path
  // Written at the edge closing the end byte, addressed by that byte's id
  // The next start byte is on the byte bus one cycle later at the earliest,
  // so a same-stream packet right behind reads the fresh value
  always_ff @(posedge clk)
  begin
    if (save_en)
    begin
      state_mem[byte_id] <= save_state;
    end
  end

endmodule

`default_nettype wire

// File: rtl/literal_dfa.sv
`timescale 1ns/1ns
`default_nettype none

module literal_dfa #(
  parameter logic [8*match_pkg::MAX_PATTERN_LEN-1:0] PATTERN = "HTTP",
  parameter int PATTERN_LEN = 4
) (
  input  wire match_pkg::dfa_state_t  cur_state,
  input  wire logic [7:0]             char_in,
  output match_pkg::dfa_state_t       next_state,
  output logic                        accept
);

  localparam int NUM_SLOTS = 2**match_pkg::STATE_W;

  // Literal split into bytes, index 0 is the first byte of the literal
  logic [7:0] pat_bytes [NUM_SLOTS];

  // State after the byte, before the full-match wrap to zero
  match_pkg::dfa_state_t step;

  // First byte sits in the top byte of the PATTERN_LEN-byte field
  for (genvar i = 0; i < NUM_SLOTS; i++)
  begin : g_pat
    if (i < PATTERN_LEN)
    begin : g_used
      assign pat_bytes[i] = PATTERN[8*(PATTERN_LEN-1-i) +: 8];
    end
    else
    begin : g_unused
      // Unreachable states
      assign pat_bytes[i] = 8'h00;
    end
  end

  always_comb
  begin
    // Extend the match, else fall back to a fresh first byte, else start over
    if (char_in == pat_bytes[cur_state])
    begin
      step = cur_state + 1'b1;
    end
    else if (char_in == pat_bytes[0])
    begin
      step = match_pkg::dfa_state_t'(1);
    end
    else
    begin
      step = '0;
    end

    // Full literal seen, report it and restart
    accept     = (step == match_pkg::dfa_state_t'(PATTERN_LEN));
    next_state = accept ? '0 : step;
  end

endmodule

`default_nettype wire

// File: rtl/match_counter.sv
`timescale 1ns/1ns
`default_nettype none

module match_counter #(
  parameter logic [8*match_pkg::MAX_PATTERN_LEN-1:0] PATTERN = "HTTP",
  parameter int PATTERN_LEN = 4
) (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             byte_valid,
  input  wire logic [7:0]                       byte_data,
  input  wire logic                             byte_sop,
  input  wire logic                             byte_eop,
  input  wire match_pkg::stream_id_t            byte_id,
  input  wire logic                             byte_new,
  input  wire match_pkg::dfa_state_t            restored_state,
  input  wire logic [match_pkg::NUM_STREAMS-1:0] stream_enable,
  input  wire logic                             clear_match,
  input  wire logic                             clear_packets,
  output logic                                  save_en,
  output match_pkg::dfa_state_t                 save_state,
  output match_pkg::count_t                     match_count,
  output match_pkg::count_t                     packet_count
);

  match_pkg::dfa_state_t run_state;
  match_pkg::dfa_state_t cur_state;
  match_pkg::dfa_state_t next_state;
  logic                  accept;
  logic                  match_flag;
  logic                  pkt_hit;
  logic                  pkt_new;
  logic                  cur_new;
  logic                  enabled;
  logic                  pkt_end;

  // Start byte picks up the stream context, later bytes follow the register
  assign cur_state = !byte_sop ? run_state :
                     byte_new  ? '0 : restored_state;

  literal_dfa #(
    .PATTERN     (PATTERN),
    .PATTERN_LEN (PATTERN_LEN)
  ) u_literal_dfa (
    .cur_state  (cur_state),
    .char_in    (byte_data),
    .next_state (next_state),
    .accept     (accept)
  );

  // Packet has matched so far, this byte included
  assign pkt_hit = accept | (match_flag & ~byte_sop);
  // Packet is the stream's first since reset
  assign cur_new = byte_sop ? byte_new : pkt_new;

  assign enabled = stream_enable[byte_id];
  assign pkt_end = byte_valid & byte_eop;

  // Save on end of packet of an enabled stream
  // A first packet of a disabled stream writes zero so the entry becomes valid
  assign save_en    = pkt_end & (enabled | cur_new);
  assign save_state = enabled ? next_state : '0;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      run_state    <= '0;
      match_flag   <= 1'b0;
      pkt_new      <= 1'b0;
      match_count  <= '0;
      packet_count <= '0;
    end
    else
    begin
      if (byte_valid)
      begin
        run_state  <= next_state;
        match_flag <= pkt_hit;
        pkt_new    <= cur_new;
      end

      // Clear wins over a coinciding increment
      if (clear_match)
        match_count <= '0;
      else if (pkt_end && enabled && pkt_hit)
        match_count <= match_count + 1'b1;

      if (clear_packets)
        packet_count <= '0;
      else if (pkt_end && enabled)
        packet_count <= packet_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module apb_regs (
  input  wire logic                                 clk,
  input  wire logic                                 rst_n,
  input  wire logic [apb_map_pkg::APB_ADDR_W-1:0]   paddr,
  input  wire logic                                 psel,
  input  wire logic                                 penable,
  input  wire logic                                 pwrite,
  input  wire apb_map_pkg::apb_data_t               pwdata,
  output apb_map_pkg::apb_data_t                    prdata,
  output logic                                      pready,
  output logic                                      pslverr,
  input  wire match_pkg::count_t                    match_count,
  input  wire match_pkg::count_t                    packet_count,
  output logic [match_pkg::NUM_STREAMS-1:0]         stream_enable,
  output logic                                      clear_match,
  output logic                                      clear_packets
);

  logic access;
  logic wr_en;
  logic addr_hit;

  // Zero wait states, every transfer ends in its access phase
  assign pready = 1'b1;
  assign access = psel & penable;
  assign wr_en  = access & pwrite;

  // Address decode and read mux
  always_comb
  begin
    addr_hit = 1'b1;
    case (paddr)
      apb_map_pkg::ADDR_ENABLE_LO:
        prdata = stream_enable[31:0];
      apb_map_pkg::ADDR_ENABLE_HI:
        prdata = stream_enable[63:32];
      apb_map_pkg::ADDR_MATCH_COUNT:
        prdata = apb_map_pkg::apb_data_t'(match_count);
      apb_map_pkg::ADDR_PACKET_COUNT:
        prdata = apb_map_pkg::apb_data_t'(packet_count);
      default:
      begin
        prdata   = '0;
        addr_hit = 1'b0;
      end
    endcase
  end

  // Error only in the access phase of an unmapped transfer
  assign pslverr = access & ~addr_hit;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      stream_enable <= '0;
      clear_match   <= 1'b0;
      clear_packets <= 1'b0;
    end
    else
    begin
      // Enable bits seen by the datapath from the next cycle
      if (wr_en && paddr == apb_map_pkg::ADDR_ENABLE_LO)
      begin
        stream_enable[31:0] <= pwdata;
      end
      if (wr_en && paddr == apb_map_pkg::ADDR_ENABLE_HI)
      begin
        stream_enable[63:32] <= pwdata;
      end

      // Counter writes ignore the data and pulse a clear
      clear_match   <= wr_en && (paddr == apb_map_pkg::ADDR_MATCH_COUNT);
      clear_packets <= wr_en && (paddr == apb_map_pkg::ADDR_PACKET_COUNT);
    end
  end

endmodule

`default_nettype wire

// File: rtl/stream_match_top.sv
`timescale 1ns/1ns
`default_nettype none

module stream_match_top #(
  // First byte in the top byte, and it must not recur later in the literal
  parameter logic [8*match_pkg::MAX_PATTERN_LEN-1:0] PATTERN = "HTTP",
  parameter int PATTERN_LEN = 4
) (
  input  wire logic                                 clk,
  input  wire logic                                 rst_n,
  // Byte port
  input  wire logic                                 in_valid,
  input  wire logic [7:0]                           in_byte,
  input  wire logic                                 in_sop,
  input  wire logic                                 in_eop,
  input  wire match_pkg::stream_id_t                in_stream_id,
  // APB port
  input  wire logic [apb_map_pkg::APB_ADDR_W-1:0]   paddr,
  input  wire logic                                 psel,
  input  wire logic                                 penable,
  input  wire logic                                 pwrite,
  input  wire apb_map_pkg::apb_data_t               pwdata,
  output apb_map_pkg::apb_data_t                    prdata,
  output logic                                      pready,
  output logic                                      pslverr
);

  // Registered byte bus
  logic                  byte_valid;
  logic [7:0]            byte_data;
  logic                  byte_sop;
  logic                  byte_eop;
  match_pkg::stream_id_t byte_id;
  logic                  byte_new;

  // Context restore and save
  match_pkg::dfa_state_t restored_state;
  logic                  save_en;
  match_pkg::dfa_state_t save_state;

  // Configuration and status
  logic [match_pkg::NUM_STREAMS-1:0] stream_enable;
  match_pkg::count_t                 match_count;
  match_pkg::count_t                 packet_count;
  logic                              clear_match;
  logic                              clear_packets;

  packet_ingress u_packet_ingress (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_byte      (in_byte),
    .in_sop       (in_sop),
    .in_eop       (in_eop),
    .in_stream_id (in_stream_id),
    .byte_valid   (byte_valid),
    .byte_data    (byte_data),
    .byte_sop     (byte_sop),
    .byte_eop     (byte_eop),
    .byte_id      (byte_id),
    .byte_new     (byte_new)
  );

  context_store u_context_store (
    .clk            (clk),
    .byte_id        (byte_id),
    .save_en        (save_en),
    .save_state     (save_state),
    .restored_state (restored_state)
  );

  match_counter #(
    .PATTERN     (PATTERN),
    .PATTERN_LEN (PATTERN_LEN)
  ) u_match_counter (
    .clk            (clk),
    .rst_n          (rst_n),
    .byte_valid     (byte_valid),
    .byte_data      (byte_data),
    .byte_sop       (byte_sop),
    .byte_eop       (byte_eop),
    .byte_id        (byte_id),
    .byte_new       (byte_new),
    .restored_state (restored_state),
    .stream_enable  (stream_enable),
    .clear_match    (clear_match),
    .clear_packets  (clear_packets),
    .save_en        (save_en),
    .save_state     (save_state),
    .match_count    (match_count),
    .packet_count   (packet_count)
  );

  apb_regs u_apb_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .paddr         (paddr),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .match_count   (match_count),
    .packet_count  (packet_count),
    .stream_enable (stream_enable),
    .clear_match   (clear_match),
    .clear_packets (clear_packets)
  );

endmodule

`default_nettype wire

// File: verification/tb_stream_match.sv
`timescale 1ns/1ns
`default_nettype none

module tb_stream_match;

  localparam int CLK_PERIOD      = 4;
  localparam int NUM_RANDOM_PKTS = 300;
  localparam int NUM_DIRECTED    = 40;
  localparam int MAX_PKT_LEN     = 12;
  localparam int MAX_GAP         = 2;
  // Worst case per packet: bytes with gaps, two enable writes and idle time
  localparam int CYCLES_PER_PKT  = MAX_PKT_LEN * (MAX_GAP + 1) + 24;
  localparam int WATCHDOG_NS     =
    2 * (NUM_RANDOM_PKTS + NUM_DIRECTED) * CYCLES_PER_PKT * CLK_PERIOD;
  // Literal as the model sees it, same as the DUT default
  localparam string LITERAL = "HTTP";

  logic clk;
  logic rst_n;
  logic in_valid;
  logic [7:0] in_byte;
  logic in_sop;
  logic in_eop;
  match_pkg::stream_id_t in_stream_id;
  logic [apb_map_pkg::APB_ADDR_W-1:0] paddr;
  logic psel;
  logic penable;
  logic pwrite;
  apb_map_pkg::apb_data_t pwdata;
  apb_map_pkg::apb_data_t prdata;
  logic pready;
  logic pslverr;

  // Reference model state
  int model_state [match_pkg::NUM_STREAMS];
  logic model_seen [match_pkg::NUM_STREAMS];
  logic [match_pkg::NUM_STREAMS-1:0] enable_model;
  match_pkg::count_t exp_matches;
  match_pkg::count_t exp_packets;

  stream_match_top u_stream_match_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_byte      (in_byte),
    .in_sop       (in_sop),
    .in_eop       (in_eop),
    .in_stream_id (in_stream_id),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Timeout guard sized from the packet budget of the whole run
  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $fatal(1, "Simulation stopped by the watchdog");
  end

  // Literal rule on one packet: extend, else restart on first byte, else zero
  // Never-seen streams start at zero, only enabled packets save their state
  function automatic logic ref_packet(input match_pkg::stream_id_t id,
                                      input logic [7:0] data [$], input logic en);
    int s;
    logic hit;
    s   = model_seen[id] ? model_state[id] : 0;
    hit = 1'b0;
    foreach (data[i])
    begin
      if (data[i] == LITERAL[s])
        s = s + 1;
      else if (data[i] == LITERAL[0])
        s = 1;
      else
        s = 0;
      if (s == LITERAL.len())
      begin
        hit = 1'b1;
        s   = 0;
      end
    end
    if (en)
      model_state[id] = s;
    model_seen[id] = 1'b1;
    return hit;
  endfunction

  // Biased toward the literal letters so matches and near misses are common
  function automatic logic [7:0] pick_byte();
    int r;
    r = $urandom_range(9, 0);
    if (r < 3)
      return "H";
    else if (r < 6)
      return "T";
    else if (r < 8)
      return "P";
    else if (r == 8)
      return "X";
    return 8'($urandom);
  endfunction

  task automatic check_count(input match_pkg::count_t got, input match_pkg::count_t exp,
                             input string what);
    if (got !== exp)
    begin
      $display("FAIL @%0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic check_data(input apb_map_pkg::apb_data_t got,
                            input apb_map_pkg::apb_data_t exp, input string what);
    if (got !== exp)
    begin
      $display("FAIL @%0t ns: %s is %08h, expected %08h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("FAIL @%0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
      in_valid = 1'b0;
      in_sop   = 1'b0;
      in_eop   = 1'b0;
    end
  endtask

  // Setup phase also idles the byte port, so a held last byte is not repeated
  task automatic apb_access(input logic [7:0] addr, input logic wr,
                            input apb_map_pkg::apb_data_t wdata,
                            output apb_map_pkg::apb_data_t rdata, output logic err);
    logic rdy;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    in_sop   = 1'b0;
    in_eop   = 1'b0;
    psel     = 1'b1;
    penable  = 1'b0;
    pwrite   = wr;
    paddr    = addr;
    pwdata   = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    // Zero wait states, so the access phase already holds the response
    // Sampled a step later, once the decode has settled
    #1;
    rdata = prdata;
    err   = pslverr;
    rdy   = pready;
    check_flag(rdy, 1'b1, "pready in access phase");
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input apb_map_pkg::apb_data_t data,
                           output logic err);
    apb_map_pkg::apb_data_t unused;
    apb_access(addr, 1'b1, data, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output apb_map_pkg::apb_data_t data,
                          output logic err);
    apb_access(addr, 1'b0, '0, data, err);
  endtask

  task automatic set_enables(input apb_map_pkg::apb_data_t lo, input apb_map_pkg::apb_data_t hi);
    logic err;
    apb_write(apb_map_pkg::ADDR_ENABLE_LO, lo, err);
    check_flag(err, 1'b0, "pslverr on enable write");
    apb_write(apb_map_pkg::ADDR_ENABLE_HI, hi, err);
    check_flag(err, 1'b0, "pslverr on enable write");
    enable_model = {hi, lo};
  endtask

  // Model is updated first with the enable that the DUT sees at the end byte
  task automatic send_packet(input match_pkg::stream_id_t id, input logic [7:0] data [$],
                             input int max_gap);
    logic hit;
    hit = ref_packet(id, data, enable_model[id]);
    if (enable_model[id])
    begin
      exp_packets = exp_packets + 1'b1;
      if (hit)
        exp_matches = exp_matches + 1'b1;
    end
    foreach (data[i])
    begin
      idle_cycles($urandom_range(max_gap, 0));
      @(posedge clk);
      #1;
      in_valid     = 1'b1;
      in_byte      = data[i];
      in_sop       = (i == 0);
      in_eop       = (i == data.size() - 1);
      in_stream_id = id;
    end
  endtask

  task automatic send_text(input match_pkg::stream_id_t id, input string s, input int max_gap);
    logic [7:0] q [$];
    for (int i = 0; i < s.len(); i++)
      q.push_back(s[i]);
    send_packet(id, q, max_gap);
  endtask

  // Counters settle two edges after the end byte, idle covers that
  task automatic check_counters(input string tag);
    apb_map_pkg::apb_data_t rd;
    logic err;
    idle_cycles(4);
    apb_read(apb_map_pkg::ADDR_MATCH_COUNT, rd, err);
    check_flag(err, 1'b0, "pslverr on counter read");
    check_data(rd >> match_pkg::COUNT_W, '0, "match count upper bits");
    check_count(match_pkg::count_t'(rd), exp_matches, {tag, ": match count"});
    apb_read(apb_map_pkg::ADDR_PACKET_COUNT, rd, err);
    check_flag(err, 1'b0, "pslverr on counter read");
    check_data(rd >> match_pkg::COUNT_W, '0, "packet count upper bits");
    check_count(match_pkg::count_t'(rd), exp_packets, {tag, ": packet count"});
  endtask

  initial
  begin : main_seq
    int unsigned seed_sink;
    apb_map_pkg::apb_data_t rd;
    logic err;
    logic [7:0] q [$];
    match_pkg::stream_id_t id;
    int len;
    seed_sink = $urandom(28);
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_byte = '0;
    in_sop = 1'b0;
    in_eop = 1'b0;
    in_stream_id = '0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    enable_model = '0;
    exp_matches = '0;
    exp_packets = '0;
    for (int i = 0; i < match_pkg::NUM_STREAMS; i++)
    begin
      model_state[i] = 0;
      model_seen[i]  = 1'b0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Register access and unmapped addresses
    check_counters("after reset");
    set_enables(32'hA5A5_0F0F, 32'h1234_5678);
    apb_read(apb_map_pkg::ADDR_ENABLE_LO, rd, err);
    check_data(rd, 32'hA5A5_0F0F, "enable low readback");
    apb_read(apb_map_pkg::ADDR_ENABLE_HI, rd, err);
    check_data(rd, 32'h1234_5678, "enable high readback");
    apb_read(8'h10, rd, err);
    check_flag(err, 1'b1, "pslverr on unmapped read");
    apb_write(8'h40, 32'hFFFF_FFFF, err);
    check_flag(err, 1'b1, "pslverr on unmapped write");
    set_enables('1, '1);

    // One count per matching packet, HHTTP matches through the fallback
    send_text(1, "xHTTPx", 1);
    send_text(2, "HTTPHTTP", 1);
    send_text(3, "HTTXP", 1);
    send_text(4, "HHTTP", 1);
    check_counters("single packets");

    // Literal split over two packets of one stream
    send_text(5, "aHT", 1);
    send_text(6, "zzP", 1);
    send_text(5, "TPq", 1);
    send_text(7, "HT", 0);
    send_text(7, "TP", 0);
    check_counters("across packets");

    // Disabled streams neither count nor save
    send_text(9, "xHT", 1);
    set_enables(~32'h0000_0300, '1);
    send_text(8, "HT", 1);
    send_text(9, "QQ", 1);
    send_text(9, "HTTP", 1);
    check_counters("disabled streams");
    set_enables('1, '1);
    send_text(9, "TP", 1);
    send_text(8, "TP", 1);
    check_counters("after re-enable");

    // Counter clear
    apb_write(apb_map_pkg::ADDR_MATCH_COUNT, 32'hFFFF_FFFF, err);
    exp_matches = '0;
    check_counters("match clear");
    apb_write(apb_map_pkg::ADDR_PACKET_COUNT, 32'h0, err);
    exp_packets = '0;
    check_counters("packet clear");
    send_text(10, "HTTP", 1);
    check_counters("after clear");

    // Random traffic, mostly on a few streams so packets chain often
    for (int n = 0; n < NUM_RANDOM_PKTS; n++)
    begin
      if ($urandom_range(7, 0) == 0)
        set_enables($urandom, $urandom);
      if ($urandom_range(3, 0) == 0)
        id = match_pkg::stream_id_t'($urandom_range(63, 0));
      else
        id = match_pkg::stream_id_t'($urandom_range(7, 0));
      len = $urandom_range(MAX_PKT_LEN, 1);
      q.delete();
      repeat (len)
        q.push_back(pick_byte());
      send_packet(id, q, MAX_GAP);
      idle_cycles($urandom_range(MAX_GAP, 0));
      if (n % 50 == 49)
        check_counters("random traffic");
    end
    check_counters("random traffic end");

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
rtl/match_pkg.sv
rtl/apb_map_pkg.sv
rtl/packet_ingress.sv
rtl/context_store.sv
rtl/literal_dfa.sv
rtl/match_counter.sv
rtl/apb_regs.sv
rtl/stream_match_top.sv
verification/tb_stream_match.sv

// File: Bender.yml
package:
  name: stream_match

sources:
  - rtl/match_pkg.sv
  - rtl/apb_map_pkg.sv
  - rtl/packet_ingress.sv
  - rtl/context_store.sv
  - rtl/literal_dfa.sv
  - rtl/match_counter.sv
  - rtl/apb_regs.sv
  - rtl/stream_match_top.sv
  - target: test
    files:
      - verification/tb_stream_match.sv
